//--- src/raster_pkg.sv
package raster_pkg;

    localparam int CMD_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;
    localparam int FB_SIZE_WIDTH = 16;

    typedef logic [31:0] pixel_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [FB_SIZE_WIDTH-1:0] fb_size_t;

    // Opcodes outside this list are consumed like a NOP
    typedef enum logic [3:0]
    {
        OP_NOP  = 4'd0,
        OP_FILL = 4'd1,
        OP_SWAP = 4'd2
    } cmd_op_t;

    // First word of every command
    typedef struct packed
    {
        cmd_op_t                                 op;
        logic [CMD_WIDTH-FB_SIZE_WIDTH-5:0]      reserved;
        fb_size_t                                count;
    } cmd_header_t;

    // The parser reads the same stream word as a header or as a payload word
    typedef union packed
    {
        cmd_header_t            header;
        logic [CMD_WIDTH-1:0]   raw;
    } cmd_word_t;

endpackage

//--- src/mem_if.sv
interface mem_if;
    import raster_pkg::*;

    logic   req_valid;
    logic   req_ready;
    logic   req_write;
    addr_t  req_addr;
    pixel_t req_data;

    // Read data returns in request order and cannot be stalled
    logic   rsp_valid;
    pixel_t rsp_data;

    modport master
    (
        output req_valid,
        output req_write,
        output req_addr,
        output req_data,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport slave
    (
        input  req_valid,
        input  req_write,
        input  req_addr,
        input  req_data,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );
endinterface

//--- src/fb_swap_if.sv
interface fb_swap_if;
    import raster_pkg::*;

    logic     swap_fb;
    addr_t    fb_addr;
    fb_size_t fb_size;
    // Pulses once the last word of the frame has left the reader
    logic     fb_swapped;

    modport parser
    (
        output swap_fb,
        output fb_addr,
        output fb_size,
        input  fb_swapped
    );

    modport reader
    (
        input  swap_fb,
        input  fb_addr,
        input  fb_size,
        output fb_swapped
    );
endinterface

//--- src/stream_fifo.sv
module stream_fifo #(
    parameter int DEPTH = 8
)
(
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic                     wr_valid,
    input  raster_pkg::pixel_t       wr_data,

    output logic                     rd_valid,
    input  logic                     rd_ready,
    output raster_pkg::pixel_t       rd_data,

    output logic [$clog2(DEPTH):0]   level
);
    import raster_pkg::*;

    pixel_t                    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]  wr_ptr;
    logic [$clog2(DEPTH)-1:0]  rd_ptr;
    logic                      do_rd;

    assign rd_valid = (level != '0);
    assign rd_data = mem[rd_ptr];
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge aclk)
    begin
        if (wr_valid)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end
        else
        begin
            if (wr_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_valid, do_rd})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    no_write_when_full: assert property (@(posedge aclk) disable iff (!rst_n)
        wr_valid |-> level < DEPTH);
endmodule

//--- src/command_parser.sv
module command_parser
(
    input  logic                  aclk,
    input  logic                  rst_n,

    input  logic                  s_cmd_axis_tvalid,
    output logic                  s_cmd_axis_tready,
    input  raster_pkg::cmd_word_t s_cmd_axis_tdata,

    mem_if.master                 mem,
    fb_swap_if.parser             swap
);
    import raster_pkg::*;

    typedef enum logic [2:0]
    {
        ST_HEADER,
        ST_ADDR,
        ST_COLOR,
        ST_FILL,
        ST_SWAP_WAIT
    } state_t;

    state_t   state;
    logic     is_swap;
    fb_size_t remaining;
    addr_t    word_addr;
    pixel_t   color;
    logic     cmd_take;
    logic     write_take;
    logic     swap_open;

    assign s_cmd_axis_tready = (state == ST_HEADER) || (state == ST_ADDR) || (state == ST_COLOR);
    assign cmd_take = s_cmd_axis_tvalid && s_cmd_axis_tready;

    // The fill loop is a write-only master
    assign mem.req_valid = (state == ST_FILL);
    assign mem.req_write = 1'b1;
    assign mem.req_addr = word_addr;
    assign mem.req_data = color;
    assign write_take = mem.req_valid && mem.req_ready;

    // For a SWAP the address and count registers describe the frame
    assign swap.fb_addr = word_addr;
    assign swap.fb_size = remaining;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_HEADER;
            is_swap <= 1'b0;
            remaining <= '0;
            swap.swap_fb <= 1'b0;
        end
        else
        begin
            swap.swap_fb <= 1'b0;
            case (state)
                ST_HEADER:
                    if (cmd_take)
                    begin
                        remaining <= s_cmd_axis_tdata.header.count;
                        case (s_cmd_axis_tdata.header.op)
                            OP_FILL:
                            begin
                                is_swap <= 1'b0;
                                state <= ST_ADDR;
                            end
                            OP_SWAP:
                            begin
                                is_swap <= 1'b1;
                                state <= ST_ADDR;
                            end
                            // NOP and unknown opcodes are a single word
                            default: state <= ST_HEADER;
                        endcase
                    end
                ST_ADDR:
                    if (cmd_take)
                    begin
                        if (is_swap)
                        begin
                            swap.swap_fb <= 1'b1;
                            state <= ST_SWAP_WAIT;
                        end
                        else
                        begin
                            state <= ST_COLOR;
                        end
                    end
                ST_COLOR:
                    if (cmd_take)
                    begin
                        state <= (remaining == '0) ? ST_HEADER : ST_FILL;
                    end
                ST_FILL:
                    if (write_take)
                    begin
                        remaining <= remaining - 1'b1;
                        if (remaining == fb_size_t'(1))
                        begin
                            state <= ST_HEADER;
                        end
                    end
                ST_SWAP_WAIT:
                    if (swap.fb_swapped)
                    begin
                        state <= ST_HEADER;
                    end
                default: state <= ST_HEADER;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (cmd_take && (state == ST_ADDR))
        begin
            word_addr <= s_cmd_axis_tdata.raw[ADDR_WIDTH-1:0];
        end
        else if (write_take)
        begin
            word_addr <= word_addr + 1'b1;
        end
        if (cmd_take && (state == ST_COLOR))
        begin
            color <= s_cmd_axis_tdata.raw;
        end
    end

    // Open from the swap request until the reader reports the frame done
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            swap_open <= 1'b0;
        end
        else if (swap.swap_fb)
        begin
            swap_open <= 1'b1;
        end
        else if (swap.fb_swapped)
        begin
            swap_open <= 1'b0;
        end
    end

    swap_not_overlapping: assert property (@(posedge aclk) disable iff (!rst_n)
        swap.swap_fb |-> !swap_open);

    swap_done_matches_request: assert property (@(posedge aclk) disable iff (!rst_n)
        swap.fb_swapped |-> swap_open);
endmodule

//--- src/mem_arbiter.sv
module mem_arbiter
(
    input  logic  aclk,
    input  logic  rst_n,

    mem_if.slave  writer,
    mem_if.slave  reader,
    mem_if.master mem
);
    // A select of 0 picks the writer and 1 picks the reader
    logic rr_ptr;
    logic hold;
    logic hold_sel;
    logic sel;

    always_comb
    begin
        if (hold)
        begin
            sel = hold_sel;
        end
        else if (writer.req_valid && reader.req_valid)
        begin
            sel = rr_ptr;
        end
        else
        begin
            sel = reader.req_valid;
        end
    end

    assign mem.req_valid = sel ? reader.req_valid : writer.req_valid;
    assign mem.req_write = sel ? reader.req_write : writer.req_write;
    assign mem.req_addr = sel ? reader.req_addr : writer.req_addr;
    assign mem.req_data = sel ? reader.req_data : writer.req_data;

    assign writer.req_ready = !sel && mem.req_ready;
    assign reader.req_ready = sel && mem.req_ready;

    // Only the reader issues reads, so every response belongs to it
    assign reader.rsp_valid = mem.rsp_valid;
    assign reader.rsp_data = mem.rsp_data;
    assign writer.rsp_valid = 1'b0;
    assign writer.rsp_data = '0;

    // A stalled request locks the grant and the pointer moves past each winner
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rr_ptr <= 1'b0;
            hold <= 1'b0;
            hold_sel <= 1'b0;
        end
        else if (mem.req_valid && mem.req_ready)
        begin
            hold <= 1'b0;
            rr_ptr <= !sel;
        end
        else if (mem.req_valid)
        begin
            hold <= 1'b1;
            hold_sel <= sel;
        end
    end

    req_stable_until_taken: assert property (@(posedge aclk) disable iff (!rst_n)
        mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.req_write)
            && $stable(mem.req_addr) && $stable(mem.req_data));
endmodule

//--- src/framebuffer_reader.sv
module framebuffer_reader #(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic               aclk,
    input  logic               rst_n,

    fb_swap_if.reader          swap,
    mem_if.master              mem,

    output logic               m_framebuffer_axis_tvalid,
    input  logic               m_framebuffer_axis_tready,
    output logic               m_framebuffer_axis_tlast,
    output raster_pkg::pixel_t m_framebuffer_axis_tdata
);
    import raster_pkg::*;

    addr_t                          rd_addr;
    fb_size_t                       issue_left;
    fb_size_t                       stream_left;
    logic [$clog2(FIFO_DEPTH):0]    inflight;
    logic [$clog2(FIFO_DEPTH):0]    fifo_level;
    logic [$clog2(FIFO_DEPTH)+1:0]  credit_used;
    logic                           req_taken;
    logic                           word_taken;

    // Every read reserves a FIFO slot, so the response always fits
    assign credit_used = inflight + fifo_level;
    assign mem.req_valid = (issue_left != '0) && (credit_used < FIFO_DEPTH);
    assign mem.req_write = 1'b0;
    assign mem.req_addr = rd_addr;
    assign mem.req_data = '0;
    assign req_taken = mem.req_valid && mem.req_ready;

    assign word_taken = m_framebuffer_axis_tvalid && m_framebuffer_axis_tready;
    assign m_framebuffer_axis_tlast = (stream_left == fb_size_t'(1));

    stream_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) stream_fifo_inst (
        .aclk(aclk),
        .rst_n(rst_n),
        .wr_valid(mem.rsp_valid),
        .wr_data(mem.rsp_data),
        .rd_valid(m_framebuffer_axis_tvalid),
        .rd_ready(m_framebuffer_axis_tready),
        .rd_data(m_framebuffer_axis_tdata),
        .level(fifo_level)
    );

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            issue_left <= '0;
            stream_left <= '0;
            inflight <= '0;
            swap.fb_swapped <= 1'b0;
        end
        else
        begin
            if (swap.swap_fb)
            begin
                issue_left <= swap.fb_size;
                stream_left <= swap.fb_size;
            end
            else
            begin
                if (req_taken)
                begin
                    issue_left <= issue_left - 1'b1;
                end
                if (word_taken)
                begin
                    stream_left <= stream_left - 1'b1;
                end
            end
            case ({req_taken, mem.rsp_valid})
                2'b10: inflight <= inflight + 1'b1;
                2'b01: inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
            swap.fb_swapped <= word_taken && m_framebuffer_axis_tlast;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (swap.swap_fb)
        begin
            rd_addr <= swap.fb_addr;
        end
        else if (req_taken)
        begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    credit_within_fifo: assert property (@(posedge aclk) disable iff (!rst_n)
        credit_used <= FIFO_DEPTH);
endmodule

//--- src/raster_system.sv
module raster_system
(
    input  logic                              aclk,
    input  logic                              rst_n,

    input  logic                              s_cmd_axis_tvalid,
    output logic                              s_cmd_axis_tready,
    input  logic [raster_pkg::CMD_WIDTH-1:0]  s_cmd_axis_tdata,

    output logic                              m_framebuffer_axis_tvalid,
    input  logic                              m_framebuffer_axis_tready,
    output logic                              m_framebuffer_axis_tlast,
    output raster_pkg::pixel_t                m_framebuffer_axis_tdata,

    output logic                              mem_req_valid,
    input  logic                              mem_req_ready,
    output logic                              mem_req_write,
    output raster_pkg::addr_t                 mem_req_addr,
    output raster_pkg::pixel_t                mem_req_data,
    input  logic                              mem_rsp_valid,
    input  raster_pkg::pixel_t                mem_rsp_data
);
    mem_if     fill_mem();
    mem_if     fb_mem();
    mem_if     ext_mem();
    fb_swap_if swap_link();

    command_parser command_parser_inst (
        .aclk(aclk),
        .rst_n(rst_n),
        .s_cmd_axis_tvalid(s_cmd_axis_tvalid),
        .s_cmd_axis_tready(s_cmd_axis_tready),
        .s_cmd_axis_tdata(s_cmd_axis_tdata),
        .mem(fill_mem.master),
        .swap(swap_link.parser)
    );

    framebuffer_reader framebuffer_reader_inst (
        .aclk(aclk),
        .rst_n(rst_n),
        .swap(swap_link.reader),
        .mem(fb_mem.master),
        .m_framebuffer_axis_tvalid(m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready(m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast(m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata(m_framebuffer_axis_tdata)
    );

    mem_arbiter mem_arbiter_inst (
        .aclk(aclk),
        .rst_n(rst_n),
        .writer(fill_mem.slave),
        .reader(fb_mem.slave),
        .mem(ext_mem.master)
    );

    // The shared memory port leaves the chip as plain signals
    assign mem_req_valid = ext_mem.req_valid;
    assign mem_req_write = ext_mem.req_write;
    assign mem_req_addr = ext_mem.req_addr;
    assign mem_req_data = ext_mem.req_data;
    assign ext_mem.req_ready = mem_req_ready;
    assign ext_mem.rsp_valid = mem_rsp_valid;
    assign ext_mem.rsp_data = mem_rsp_data;
endmodule

//--- test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Memory contents as the command stream should leave them
pixel_t ref_mem [MEM_WORDS];

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Every address bit changes the start-up word
function automatic pixel_t initial_word(input int index);
    return pixel_t'(index + 1) * 32'h9e37_79b9;
endfunction

// A FILL writes its colour to count consecutive words from base
task automatic model_fill(input addr_t base, input fb_size_t count, input pixel_t color);
    addr_t a;
    a = base;
    for (int n = 0; n < int'(count); n++)
    begin
        ref_mem[a[9:0]] = color;
        a = a + 1'b1;
    end
endtask

function automatic pixel_t expected_word(input addr_t addr);
    return ref_mem[addr[9:0]];
endfunction

task automatic check_pixel(input string what, input pixel_t expected, input pixel_t actual);
    if (actual !== expected)
    begin
        $display("FAILED %s, %s: expected %08h, actual %08h",
                 test_name, what, expected, actual);
        test_errors++;
    end
endtask

task automatic check_last(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("FAILED %s, %s: expected tlast %0b, actual %0b",
                 test_name, what, expected, actual);
        test_errors++;
    end
endtask

// Handshake flags such as valid and ready
task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("FAILED %s, %s: expected %0b, actual %0b",
                 test_name, what, expected, actual);
        test_errors++;
    end
endtask

`endif

//--- test/tb_raster_system.sv
module tb_raster_system;
    import raster_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam logic [31:0] SEED = 32'h3982_8512;

    logic      aclk;
    logic      rst_n;
    logic      s_cmd_axis_tvalid;
    logic      s_cmd_axis_tready;
    cmd_word_t s_cmd_axis_tdata;
    logic      m_framebuffer_axis_tvalid;
    logic      m_framebuffer_axis_tready;
    logic      m_framebuffer_axis_tlast;
    pixel_t    m_framebuffer_axis_tdata;
    logic      mem_req_valid;
    logic      mem_req_ready;
    logic      mem_req_write;
    addr_t     mem_req_addr;
    pixel_t    mem_req_data;
    logic      mem_rsp_valid;
    pixel_t    mem_rsp_data;

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          stray_words;
    logic        collecting;
    logic        heavy_stalls;
    logic [31:0] stim_rng;
    pixel_t      model_mem [MEM_WORDS];
    pixel_t      expected_frame [$];

    `include "tb_checks.svh"

    raster_system raster_system_inst (
        .aclk(aclk),
        .rst_n(rst_n),
        .s_cmd_axis_tvalid(s_cmd_axis_tvalid),
        .s_cmd_axis_tready(s_cmd_axis_tready),
        .s_cmd_axis_tdata(s_cmd_axis_tdata),
        .m_framebuffer_axis_tvalid(m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready(m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast(m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata(m_framebuffer_axis_tdata),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_write(mem_req_write),
        .mem_req_addr(mem_req_addr),
        .mem_req_data(mem_req_data),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Memory model and stream sink sample at the falling edge and drive 2 units after the rise
    initial
    begin : memory_model
        pixel_t      rsp_q [$];
        int          due_q [$];
        logic [31:0] env_rng;
        int          cycle;
        env_rng = ~SEED;
        cycle = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        m_framebuffer_axis_tready = 1'b0;
        forever
        begin
            @(negedge aclk);
            if (rst_n && mem_req_valid && mem_req_ready)
            begin
                if (mem_req_write)
                begin
                    model_mem[mem_req_addr[9:0]] = mem_req_data;
                end
                else
                begin
                    env_rng = xorshift32(env_rng);
                    rsp_q.push_back(model_mem[mem_req_addr[9:0]]);
                    due_q.push_back(cycle + 1 + int'(env_rng[2:0]));
                end
            end
            if (rst_n && m_framebuffer_axis_tvalid && m_framebuffer_axis_tready && !collecting)
            begin
                stray_words++;
            end
            @(posedge aclk);
            cycle++;
            #2;
            // Responses leave in request order and none before its due cycle
            if (rsp_q.size() != 0 && due_q[0] <= cycle)
            begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = rsp_q.pop_front();
                void'(due_q.pop_front());
            end
            else
            begin
                mem_rsp_valid = 1'b0;
            end
            env_rng = xorshift32(env_rng);
            if (heavy_stalls)
            begin
                mem_req_ready = (env_rng[1:0] == 2'b00);
                m_framebuffer_axis_tready = (env_rng[3:2] == 2'b00);
            end
            else
            begin
                mem_req_ready = (env_rng[1:0] != 2'b00);
                m_framebuffer_axis_tready = (env_rng[3:2] != 2'b00);
            end
        end
    end

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    task automatic abort_on_timeout(input string what);
        total_errors++;
        $display("Timeout in test %s: %s", test_name, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        stray_words = 0;
    endtask

    task automatic finish_test();
        if (stray_words != 0)
        begin
            $display("Test %s: %0d stream words appeared with no frame requested",
                     test_name, stray_words);
            test_errors++;
        end
        if (test_errors == 0)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
        total_errors += test_errors;
        tests_run++;
    endtask

    task automatic idle_cycles(input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(posedge aclk);
        end
        #2;
    endtask

    // Called at 2 units after a rising edge and returns at the same point
    task automatic send_word(input cmd_word_t word);
        int waited;
        waited = 0;
        s_cmd_axis_tdata = word;
        s_cmd_axis_tvalid = 1'b1;
        @(negedge aclk);
        while (!s_cmd_axis_tready && waited < TIMEOUT_CYCLES)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!s_cmd_axis_tready)
        begin
            abort_on_timeout("a command word was never accepted");
        end
        else
        begin
            @(posedge aclk);
            #2;
            s_cmd_axis_tvalid = 1'b0;
        end
    endtask

    task automatic send_fill(input addr_t base, input fb_size_t count, input pixel_t color);
        cmd_header_t h;
        cmd_word_t   w;
        h.op = OP_FILL;
        h.reserved = '0;
        h.count = count;
        w.header = h;
        send_word(w);
        w.raw = 32'(base);
        send_word(w);
        w.raw = color;
        send_word(w);
        model_fill(base, count, color);
    endtask

    task automatic random_fill(input addr_t base, input int region);
        int     offset;
        int     count;
        pixel_t color;
        offset = int'(next_stim() % 32'(region));
        count = 1 + int'(next_stim() % 32'(region - offset));
        color = next_stim();
        send_fill(base + addr_t'(offset), fb_size_t'(count), color);
    endtask

    // The expected frame is taken from the reference when the SWAP is sent
    task automatic send_swap(input addr_t base, input int size);
        cmd_header_t h;
        cmd_word_t   w;
        expected_frame.delete();
        for (int n = 0; n < size; n++)
        begin
            expected_frame.push_back(expected_word(base + addr_t'(n)));
        end
        h.op = OP_SWAP;
        h.reserved = '0;
        h.count = fb_size_t'(size);
        w.header = h;
        send_word(w);
        w.raw = 32'(base);
        send_word(w);
    endtask

    task automatic receive_frame(input int size);
        int got;
        int waited;
        got = 0;
        waited = 0;
        collecting = 1'b1;
        while (got < size && waited < TIMEOUT_CYCLES)
        begin
            @(negedge aclk);
            if (m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
            begin
                check_pixel($sformatf("word %0d", got), expected_frame[got],
                            m_framebuffer_axis_tdata);
                check_last($sformatf("word %0d", got), got == size - 1,
                           m_framebuffer_axis_tlast);
                got++;
                waited = 0;
            end
            else
            begin
                waited++;
            end
        end
        if (got < size)
        begin
            abort_on_timeout($sformatf("frame stopped after %0d of %0d words", got, size));
        end
        else
        begin
            @(posedge aclk);
            #2;
            collecting = 1'b0;
        end
    endtask

    task automatic run_swap(input addr_t base, input int size);
        send_swap(base, size);
        receive_frame(size);
    endtask

    // NOP headers and opcodes outside the list carry random count fields
    task automatic send_junk_headers(input int words);
        cmd_header_t h;
        cmd_word_t   w;
        for (int k = 0; k < words; k++)
        begin
            h.op = (k % 2 == 0) ? OP_NOP : cmd_op_t'(4'd3 + 4'(next_stim() % 13));
            h.reserved = 12'(next_stim());
            h.count = fb_size_t'(next_stim());
            w.header = h;
            send_word(w);
        end
    endtask

    task automatic set_stalls(input logic heavy);
        @(negedge aclk);
        heavy_stalls = heavy;
        @(posedge aclk);
        #2;
    endtask

    initial
    begin : test_sequence
        rst_n = 1'b0;
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tdata = '0;
        collecting = 1'b0;
        heavy_stalls = 1'b0;
        stray_words = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        stim_rng = SEED;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            model_mem[i] = initial_word(i);
            ref_mem[i] = initial_word(i);
        end
        repeat (10) @(posedge aclk);
        #2;
        rst_n = 1'b1;

        start_test("reset_values");
        @(negedge aclk);
        check_flag("framebuffer tvalid", 1'b0, m_framebuffer_axis_tvalid);
        check_flag("memory request valid", 1'b0, mem_req_valid);
        check_flag("command tready", 1'b1, s_cmd_axis_tready);
        @(posedge aclk);
        #2;
        finish_test();

        start_test("fill_then_swap");
        for (int k = 0; k < 6; k++)
        begin
            random_fill(16'h0100, 64);
        end
        run_swap(16'h0100, 64);
        finish_test();

        start_test("tlast_position");
        random_fill(16'h0200, 16);
        run_swap(16'h0200, 1);
        run_swap(16'h0203, 2);
        run_swap(16'h0205, 9);
        finish_test();

        start_test("stalled_stream");
        set_stalls(1'b1);
        for (int k = 0; k < 4; k++)
        begin
            random_fill(16'h0280, 96);
        end
        run_swap(16'h0280, 96);
        set_stalls(1'b0);
        finish_test();

        start_test("nop_and_unknown");
        random_fill(16'h0100, 64);
        send_junk_headers(8);
        random_fill(16'h0100, 64);
        send_junk_headers(8);
        idle_cycles(40);
        run_swap(16'h0100, 64);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            check_pixel($sformatf("memory word %0d", i), ref_mem[i], model_mem[i]);
        end
        finish_test();

        // The FILL over the same region must wait until the frame has left
        start_test("blocking_swap");
        send_swap(16'h0100, 64);
        fork
            receive_frame(64);
            send_fill(16'h0100, 16'd64, next_stim());
        join
        run_swap(16'h0100, 64);
        finish_test();

        $display("tests %0d, errors %0d", tests_run, total_errors);
        if (total_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

//--- raster_system.f
+incdir+test
src/raster_pkg.sv
src/mem_if.sv
src/fb_swap_if.sv
src/stream_fifo.sv
src/command_parser.sv
src/mem_arbiter.sv
src/framebuffer_reader.sv
src/raster_system.sv
test/tb_raster_system.sv

//--- run_sim.sh
#!/bin/sh
# Compile the design and testbench with Verilator, run the simulation, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_raster_system -f raster_system.f -o tb_raster_system
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_raster_system > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
